// File: Makefile
CLK_DIV ?= 4

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module tb_spi_link \
		-GCLK_DIV=$(CLK_DIV) -f tb.f
	@out=$$(./obj_dir/Vtb_spi_link +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

lint:
	verilator --lint-only -Wall --timing --top-module tb_spi_link -f tb.f

clean:
	rm -rf obj_dir

// File: rtl/spi_clk_div.sv
`timescale 1ns/10ps

module spi_clk_div #(
   parameter int CLK_DIV = 4
) (
   input  logic clk,
   input  logic rst_n,
   input  logic div_run,
   output logic sclk,
   output logic rise_tick,
   output logic fall_tick,
   output logic frame_done
);

   localparam int PH_W  = $clog2(CLK_DIV);
   localparam int BIT_W = $clog2(spi_pkg::FRAME_BITS);

   // Clocks into the current sclk half-period
   logic [PH_W-1:0]  phase;
   // Completed bits, advanced on each falling edge
   logic [BIT_W-1:0] bit_cnt;
   logic             tick;

   // End of a half-period
   assign tick = div_run && (phase == PH_W'(CLK_DIV - 1));

   // Tick direction follows the level sclk is about to leave
   assign rise_tick = tick && !sclk;
   assign fall_tick = tick && sclk;

   // Last falling edge closes the frame
   assign frame_done = fall_tick && (bit_cnt == BIT_W'(spi_pkg::FRAME_BITS - 1));

   always_ff @(posedge clk) begin
      // Idle clears everything, sclk parks low
      if (!rst_n || !div_run) begin
         phase   <= '0;
         bit_cnt <= '0;
         sclk    <= 1'b0;
      end else begin
         if (tick) begin
            phase <= '0;
            sclk  <= ~sclk;
         end else begin
            phase <= phase + 1'b1;
         end
         if (fall_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

endmodule

// File: rtl/spi_link_top.sv
`timescale 1ns/10ps

module spi_link_top #(
   parameter int CLK_DIV = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             access_in,
   input  spi_pkg::packet_t packet_in,
   output logic             wait_out,
   output logic             access_out,
   output spi_pkg::packet_t packet_out,
   input  logic             wait_in
);

   // Timer handshake
   logic div_run;
   logic rise_tick;
   logic fall_tick;
   logic frame_done;

   // Datapath control
   logic load;
   logic shift_en;
   logic resp_valid;

   // SPI wires between master and slave
   logic sclk;
   logic mosi;
   logic miso;
   logic ss;

   // Slave to memory
   logic           mem_we;
   spi_pkg::addr_t mem_addr;
   spi_pkg::data_t mem_wdata;
   spi_pkg::data_t mem_rdata;

   //##################################################
   //# Master
   //##################################################

   spi_clk_div #(.CLK_DIV(CLK_DIV)) u_clk_div (
      .clk        (clk),
      .rst_n      (rst_n),
      .div_run    (div_run),
      .sclk       (sclk),
      .rise_tick  (rise_tick),
      .fall_tick  (fall_tick),
      .frame_done (frame_done)
   );

   spi_master_fsm u_master_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .rise_tick  (rise_tick),
      .fall_tick  (fall_tick),
      .frame_done (frame_done),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .ss         (ss),
      .div_run    (div_run),
      .load       (load),
      .shift_en   (shift_en),
      .resp_valid (resp_valid)
   );

   spi_shift_reg u_shift_reg (
      .clk        (clk),
      .rst_n      (rst_n),
      .packet_in  (packet_in),
      .load       (load),
      .shift_en   (shift_en),
      .rise_tick  (rise_tick),
      .fall_tick  (fall_tick),
      .miso       (miso),
      .resp_valid (resp_valid),
      .mosi       (mosi),
      .packet_out (packet_out)
   );

   //##################################################
   //# Slave and registers
   //##################################################

   spi_slave u_slave (
      .clk       (clk),
      .rst_n     (rst_n),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss        (ss),
      .miso      (miso),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   spi_reg_mem u_reg_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

// File: rtl/spi_master_fsm.sv
`timescale 1ns/10ps

module spi_master_fsm (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             access_in,
   input  spi_pkg::packet_t packet_in,
   input  logic             rise_tick,
   input  logic             fall_tick,
   input  logic             frame_done,
   input  logic             wait_in,
   output logic             wait_out,
   output logic             access_out,
   output logic             ss,
   output logic             div_run,
   output logic             load,
   output logic             shift_en,
   output logic             resp_valid
);

   spi_pkg::master_state_t state;
   spi_pkg::master_state_t state_nxt;

   // Write flag of the packet in flight
   logic wr_q;
   // Second gap cycle
   logic gap_cnt;
   logic accept;
   logic resp_taken;

   //##################################################
   //# Handshake decode
   //##################################################

   // Busy from acceptance until back in idle
   assign wait_out   = (state != spi_pkg::st_idle);
   assign accept     = access_in && !wait_out;
   assign resp_taken = access_out && !wait_in;

   // Packet captured by the shifter in the acceptance cycle
   assign load = accept;

   // Slave selected during setup and shifting
   assign ss = !((state == spi_pkg::st_load) || (state == spi_pkg::st_shift));

   assign div_run = (state == spi_pkg::st_shift);

   // Shift only on tick cycles of an active frame
   assign shift_en = div_run && (rise_tick || fall_tick);

   assign resp_valid = access_out;

   //##################################################
   //# Next state
   //##################################################

   always_comb begin
      state_nxt = state;
      case (state)
         spi_pkg::st_idle: begin
            if (accept) begin
               state_nxt = spi_pkg::st_load;
            end
         end
         // One cycle of mosi setup before the first edge
         spi_pkg::st_load: state_nxt = spi_pkg::st_shift;
         spi_pkg::st_shift: begin
            // Writes have no response
            if (frame_done) begin
               state_nxt = wr_q ? spi_pkg::st_gap : spi_pkg::st_respond;
            end
         end
         spi_pkg::st_respond: begin
            if (resp_taken) begin
               state_nxt = spi_pkg::st_gap;
            end
         end
         spi_pkg::st_gap: begin
            if (gap_cnt) begin
               state_nxt = spi_pkg::st_idle;
            end
         end
         default: state_nxt = spi_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= spi_pkg::st_idle;
         wr_q       <= 1'b0;
         gap_cnt    <= 1'b0;
         access_out <= 1'b0;
      end else begin
         state   <= state_nxt;
         gap_cnt <= (state == spi_pkg::st_gap) && !gap_cnt;
         if (accept) begin
            wr_q <= packet_in[$bits(spi_pkg::packet_t)-1];
         end
         // Response goes up one cycle after ss, held against wait_in
         if (resp_taken) begin
            access_out <= 1'b0;
         end else if (state == spi_pkg::st_respond) begin
            access_out <= 1'b1;
         end
      end
   end

endmodule

// File: rtl/spi_pkg.sv
package spi_pkg;

   //##################################################
   //# Widths
   //##################################################

   // Register address and register value
   typedef logic [7:0]  addr_t;
   typedef logic [31:0] data_t;

   // Host packet: write flag, address, data
   typedef logic [40:0] packet_t;

   //##################################################
   //# Frame layout
   //##################################################

   // SCLK bits per frame, flag first
   localparam int FRAME_BITS = 41;

   // Bits up to the end of the address field
   localparam int HDR_BITS = 9;

   //##################################################
   //# Master FSM
   //##################################################

   typedef enum logic [2:0] {
      st_idle,
      st_load,
      st_shift,
      st_respond,
      st_gap
   } master_state_t;

endpackage

// File: rtl/spi_reg_mem.sv
`timescale 1ns/10ps

module spi_reg_mem (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           mem_we,
   input  spi_pkg::addr_t mem_addr,
   input  spi_pkg::data_t mem_wdata,
   output spi_pkg::data_t mem_rdata
);

   // One word per address
   localparam int DEPTH = 2 ** $bits(spi_pkg::addr_t);

   spi_pkg::data_t mem [DEPTH];

   //##################################################
   //# Write port
   //##################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // All registers read zero after reset
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (mem_we) begin
         mem[mem_addr] <= mem_wdata;
      end
   end

   //##################################################
   //# Read port
   //##################################################

   // Asynchronous, slave samples it mid-frame
   assign mem_rdata = mem[mem_addr];

endmodule

// File: rtl/spi_shift_reg.sv
`timescale 1ns/10ps

module spi_shift_reg (
   input  logic             clk,
   input  logic             rst_n,
   input  spi_pkg::packet_t packet_in,
   input  logic             load,
   input  logic             shift_en,
   input  logic             rise_tick,
   input  logic             fall_tick,
   input  logic             miso,
   input  logic             resp_valid,
   output logic             mosi,
   output spi_pkg::packet_t packet_out
);

   localparam int PW = $bits(spi_pkg::packet_t);
   localparam int DW = $bits(spi_pkg::data_t);
   localparam int AW = $bits(spi_pkg::addr_t);

   // Outgoing frame, MSB on the wire
   spi_pkg::packet_t tx;
   // Address of the packet in flight
   spi_pkg::addr_t   addr_q;
   // Last 32 miso samples
   spi_pkg::data_t   cap;
   spi_pkg::packet_t resp;

   // Mode 0: first bit valid before the first rising edge
   assign mosi = tx[PW-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx <= '0;
      end else if (load) begin
         tx <= packet_in;
      end else if (shift_en && fall_tick) begin
         tx <= {tx[PW-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         addr_q <= packet_in[DW +: AW];
      end
      // Header-time samples fall off the top
      if (shift_en && rise_tick) begin
         cap <= {cap[DW-2:0], miso};
      end
      // Frozen while the host has not taken it
      if (!resp_valid) begin
         resp <= {1'b0, addr_q, cap};
      end
   end

   assign packet_out = resp;

endmodule

// File: rtl/spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           sclk,
   input  logic           mosi,
   input  logic           ss,
   output logic           miso,
   output logic           mem_we,
   output spi_pkg::addr_t mem_addr,
   output spi_pkg::data_t mem_wdata,
   input  spi_pkg::data_t mem_rdata
);

   localparam int CNT_W = $clog2(spi_pkg::FRAME_BITS + 1);
   localparam int DW    = $bits(spi_pkg::data_t);
   localparam int AW    = $bits(spi_pkg::addr_t);

   //##################################################
   //# Pin synchronizers
   //##################################################

   // Two sync stages plus one history stage for edges
   logic [2:0] sclk_s;
   logic [2:0] ss_s;
   logic [1:0] mosi_s;
   logic       sclk_rise;
   logic       sclk_fall;
   logic       ss_rise;
   logic       sel;

   // Frame state
   logic [CNT_W-1:0]            bit_cnt;
   logic [spi_pkg::HDR_BITS-1:0] hdr;
   spi_pkg::data_t              rx;
   spi_pkg::data_t              tx;
   logic                        wr_flag;
   logic                        frame_full;

   assign sclk_rise = sclk_s[1] && !sclk_s[2];
   assign sclk_fall = !sclk_s[1] && sclk_s[2];
   assign ss_rise   = ss_s[1] && !ss_s[2];
   assign sel       = !ss_s[1];

   // Header is flag then address
   assign wr_flag    = hdr[spi_pkg::HDR_BITS-1];
   assign mem_addr   = hdr[AW-1:0];
   assign mem_wdata  = rx;
   assign frame_full = (bit_cnt == CNT_W'(spi_pkg::FRAME_BITS));

   //##################################################
   //# Control
   //##################################################

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sclk_s  <= '0;
         ss_s    <= '1;
         mosi_s  <= '0;
         bit_cnt <= '0;
         miso    <= 1'b0;
         mem_we  <= 1'b0;
      end else begin
         sclk_s <= {sclk_s[1:0], sclk};
         ss_s   <= {ss_s[1:0], ss};
         mosi_s <= {mosi_s[0], mosi};
         // Commit only complete write frames
         mem_we <= ss_rise && wr_flag && frame_full;
         if (!sel) begin
            bit_cnt <= '0;
         end else if (sclk_rise && !frame_full) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
         // Address known here, first read bit goes out
         if (sel && sclk_fall) begin
            if (bit_cnt == CNT_W'(spi_pkg::HDR_BITS)) begin
               miso <= mem_rdata[DW-1];
            end else begin
               miso <= tx[DW-1];
            end
         end
      end
   end

   //##################################################
   //# Shifters
   //##################################################

   always_ff @(posedge clk) begin
      if (sel && sclk_rise) begin
         if (bit_cnt < CNT_W'(spi_pkg::HDR_BITS)) begin
            hdr <= {hdr[spi_pkg::HDR_BITS-2:0], mosi_s[1]};
         end else begin
            rx <= {rx[DW-2:0], mosi_s[1]};
         end
      end
      // Bit 31 already on miso after the load
      if (sel && sclk_fall) begin
         if (bit_cnt == CNT_W'(spi_pkg::HDR_BITS)) begin
            tx <= {mem_rdata[DW-2:0], 1'b0};
         end else begin
            tx <= {tx[DW-2:0], 1'b0};
         end
      end
   end

endmodule

// File: tb.f
rtl/spi_pkg.sv
rtl/spi_clk_div.sv
rtl/spi_master_fsm.sv
rtl/spi_shift_reg.sv
rtl/spi_slave.sv
rtl/spi_reg_mem.sv
rtl/spi_link_top.sv
test/spi_link_props.sv
test/tb_spi_link.sv

// File: test/spi_link_props.sv
`timescale 1ns/10ps

module spi_link_props (
   input logic             clk,
   input logic             rst_n,
   input logic             wait_out,
   input logic             access_out,
   input logic             wait_in,
   input logic             ss,
   input logic             sclk,
   input spi_pkg::packet_t packet_out
);

   // Failure count per property
   int err_reset = 0;
   int err_busy  = 0;
   int err_sclk  = 0;
   int err_hold  = 0;

   //##################################################
   //# Reset and framing
   //##################################################

   // Host and SPI pins parked after a reset cycle
   a_reset: assert property (@(posedge clk)
      !rst_n |=> (!wait_out && !access_out && ss && !sclk))
      else begin
         $error("outputs not in reset state after a reset cycle");
         err_reset = err_reset + 1;
      end

   // Slave selected only while the master is busy
   a_busy: assert property (@(posedge clk) disable iff (!rst_n)
      !ss |-> wait_out)
      else begin
         $error("ss low while wait_out is low");
         err_busy = err_busy + 1;
      end

   // Mode 0 idle level
   a_sclk: assert property (@(posedge clk) disable iff (!rst_n)
      ss |-> !sclk)
      else begin
         $error("sclk high while ss is high");
         err_sclk = err_sclk + 1;
      end

   //##################################################
   //# Response hold
   //##################################################

   // Response frozen until the host drops wait_in
   a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else begin
         $error("response dropped or changed under wait_in");
         err_hold = err_hold + 1;
      end

endmodule

bind spi_link_top spi_link_props u_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .wait_out   (wait_out),
   .access_out (access_out),
   .wait_in    (wait_in),
   .ss         (ss),
   .sclk       (sclk),
   .packet_out (packet_out)
);

// File: test/tb_spi_link.sv
`timescale 1ns/10ps

module tb_spi_link #(
   parameter int CLK_DIV = 4
);

   // About 40 transactions of one frame each plus stall cycles
   localparam int XFER_CYCLES    = spi_pkg::FRAME_BITS * 2 * CLK_DIV + 72;
   localparam int TIMEOUT_CYCLES = 40 * XFER_CYCLES + 500;

   logic             clk;
   logic             rst_n;
   logic             access_in;
   spi_pkg::packet_t packet_in;
   logic             wait_out;
   logic             access_out;
   spi_pkg::packet_t packet_out;
   logic             wait_in;

   // Reference model of the register memory
   spi_pkg::data_t shadow [256];

   int     errors;
   int     accepts;
   int     frames;
   int     cycles;
   integer seed;
   logic   ss_q;

   spi_link_top #(.CLK_DIV(CLK_DIV)) dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //##################################################
   //# Monitors and timeout
   //##################################################

   // One ss fall per frame on the wire
   always @(negedge clk) begin
      if (rst_n && ss_q && !dut0.ss) begin
         frames++;
      end
      ss_q = dut0.ss;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: link still busy after %0d cycles", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic int prop_failures();
      return dut0.u_props.err_reset + dut0.u_props.err_busy +
             dut0.u_props.err_sclk + dut0.u_props.err_hold;
   endfunction

   task automatic check_value(input string name, input spi_pkg::packet_t exp,
                              input spi_pkg::packet_t act);
      assert (act === exp) else begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   //##################################################
   //# Host side
   //##################################################

   // Request held until accepted and then for hold more cycles
   task automatic send_packet(input logic wr, input spi_pkg::addr_t a,
                              input spi_pkg::data_t d, input int hold);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= {wr, a, d};
      @(negedge clk);
      while (wait_out) begin
         @(negedge clk);
      end
      @(posedge clk);
      accepts++;
      repeat (hold) @(posedge clk);
      access_in <= 1'b0;
   endtask

   // Wait for idle while watching for a stray write response
   task automatic wait_idle(input logic is_write);
      @(negedge clk);
      while (wait_out) begin
         assert (!(is_write && access_out)) else begin
            $display("Error: access_out rose during a write");
            errors++;
         end
         @(negedge clk);
      end
   endtask

   task automatic write_reg(input spi_pkg::addr_t a, input spi_pkg::data_t d,
                            input int hold);
      send_packet(1'b1, a, d, hold);
      shadow[a] = d;
      wait_idle(1'b1);
   endtask

   // Read with the response stalled for stall cycles
   task automatic read_reg(input spi_pkg::addr_t a, input int stall, input string name);
      spi_pkg::packet_t held;
      int               f0;
      send_packet(1'b0, a, '0, 0);
      wait_in <= (stall > 0);
      @(negedge clk);
      while (!access_out) begin
         @(negedge clk);
      end
      held = packet_out;
      f0   = frames;
      check_value(name, {1'b0, a, shadow[a]}, packet_out);
      // Competing write offered while the response is stalled
      if (stall > 0) begin
         @(posedge clk);
         access_in <= 1'b1;
         packet_in <= {1'b1, a, ~shadow[a]};
      end
      repeat (stall) begin
         @(negedge clk);
         assert (access_out && packet_out === held && wait_out && frames == f0) else begin
            $display("Error: response in %s not held under wait_in", name);
            errors++;
         end
      end
      @(posedge clk);
      wait_in   <= 1'b0;
      access_in <= 1'b0;
      wait_idle(1'b0);
   endtask

   //##################################################
   //# Stimulus
   //##################################################

   initial begin
      logic [31:0]    rnd;
      spi_pkg::addr_t a;
      spi_pkg::data_t d;
      rst_n     = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      errors    = 0;
      accepts   = 0;
      frames    = 0;
      cycles    = 0;
      ss_q      = 1'b1;
      seed      = 32'h6424_48aa;
      for (int i = 0; i < 256; i++) begin
         shadow[i] = '0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // Idle outputs and zeroed registers
      @(negedge clk);
      check_value("reset wait_out", '0, {40'b0, wait_out});
      check_value("reset access_out", '0, {40'b0, access_out});
      check_value("reset ss", 41'd1, {40'b0, dut0.ss});
      read_reg(8'h00, 0, "reset read zero");
      rnd = $random(seed);
      read_reg(rnd[7:0], 0, "reset read random");

      // Write then read back
      write_reg(8'h5c, 32'h5a5a_1234, 0);
      read_reg(8'h5c, 0, "write read back");

      // Lone write without a response
      write_reg(8'hff, 32'h8001_7ffe, 0);

      // Random mix over a small window so reads hit written words
      for (int n = 0; n < 30; n++) begin
         rnd = $random(seed);
         a   = rnd[7:0] & 8'h1f;
         if (rnd[31]) begin
            d = $random(seed);
            write_reg(a, d, 0);
         end else begin
            read_reg(a, 0, "random read");
         end
      end

      // Response stalled by the host
      write_reg(8'h81, 32'hdead_0042, 0);
      read_reg(8'h81, 6, "stalled read");

      // Host keeps access_in up while the link is busy
      write_reg(8'h42, 32'h0f1e_2d3c, 8);
      read_reg(8'h42, 0, "held request read");

      assert (frames == accepts) else begin
         $display("Fail frame count: expected %0d, actual %0d", accepts, frames);
         errors++;
      end

      $display("Errors: %0d check, %0d property", errors, prop_failures());
      if (errors == 0 && prop_failures() == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
